// ==== cdb/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter import cdb_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            flush_i,

    input  logic      [FU_COUNT-1:0]        fifo_valid_i,
    input  cdb_info_t [FU_COUNT-1:0]        fifo_data_i,
    output logic      [FU_COUNT-1:0]        fifo_ready_o,

    output cdb_info_t [CDB_COUNT-1:0]       cdb_o
);

    logic [FU_IDX_W-1:0]                  rr_ptr;
    logic [FU_IDX_W-1:0]                  last_idx;
    logic [FU_IDX_W-1:0]                  next_ptr;
    logic [FU_COUNT-1:0]                  grant;
    logic [CDB_COUNT-1:0][FU_IDX_W-1:0]   sel_idx;
    logic [CDB_COUNT-1:0]                 sel_vld;
    cdb_info_t [CDB_COUNT-1:0]            cdb_q;

    // scan from rr_ptr, first hits fill cdb lanes in order
    always_comb begin
        int idx;
        int n_grant;
        grant    = '0;
        sel_idx  = '0;
        sel_vld  = '0;
        last_idx = rr_ptr;
        n_grant  = 0;
        for (int k = 0; k < FU_COUNT; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= FU_COUNT) idx = idx - FU_COUNT;
            if (fifo_valid_i[idx] && n_grant < CDB_COUNT) begin
                grant[idx]       = 1'b1;
                sel_idx[n_grant] = FU_IDX_W'(idx);
                sel_vld[n_grant] = 1'b1;
                last_idx         = FU_IDX_W'(idx);
                n_grant          = n_grant + 1;
            end
        end
    end

    // pointer moves just past the last winner
    assign next_ptr = (last_idx == FU_IDX_W'(FU_COUNT - 1)) ? '0 : last_idx + 1'b1;

    assign fifo_ready_o = grant; // grant doubles as the pop

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr <= '0;
            cdb_q  <= '0;
        end else if (flush_i) begin
            rr_ptr <= '0;
            cdb_q  <= '0;
        end else begin
            if (|grant) begin
                rr_ptr <= next_ptr;
            end
            for (int c = 0; c < CDB_COUNT; c++) begin
                cdb_q[c]         <= fifo_data_i[sel_idx[c]];
                cdb_q[c].w_valid <= sel_vld[c];
            end
        end
    end

    assign cdb_o = cdb_q;

endmodule

// ==== cdb/cdb_writeback_top.sv ====
`timescale 1ns/1ps

module cdb_writeback_top import cdb_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,

    input  logic      [FU_COUNT-1:0]   issue_valid_i,
    input  fu_req_t   [FU_COUNT-1:0]   issue_req_i,
    output logic      [FU_COUNT-1:0]   issue_ready_o,

    output cdb_info_t [CDB_COUNT-1:0]  cdb_o
);

    // issue fifo -> alu lane
    logic      [FU_COUNT-1:0] req_valid;
    fu_req_t   [FU_COUNT-1:0] req_data;
    logic      [FU_COUNT-1:0] req_ready;

    // alu lane -> result fifo
    logic      [FU_COUNT-1:0] res_valid;
    cdb_info_t [FU_COUNT-1:0] res_data;
    logic      [FU_COUNT-1:0] res_ready;

    // result fifo -> arbiter
    logic      [FU_COUNT-1:0] fifo_valid;
    cdb_info_t [FU_COUNT-1:0] fifo_data;
    logic      [FU_COUNT-1:0] fifo_ready;

    for (genvar i = 0; i < FU_COUNT; i++) begin : g_lane
        handshake_fifo #(
            .T     (fu_req_t),
            .DEPTH (ISSUE_DEPTH)
        ) issue_fifo_i (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .in_valid_i  (issue_valid_i[i]),
            .in_data_i   (issue_req_i[i]),
            .in_ready_o  (issue_ready_o[i]),
            .out_valid_o (req_valid[i]),
            .out_data_o  (req_data[i]),
            .out_ready_i (req_ready[i])
        );

        alu_lane alu_i (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .req_valid_i (req_valid[i]),
            .req_i       (req_data[i]),
            .req_ready_o (req_ready[i]),
            .res_valid_o (res_valid[i]),
            .res_o       (res_data[i]),
            .res_ready_i (res_ready[i])
        );

        handshake_fifo #(
            .T     (cdb_info_t),
            .DEPTH (RESULT_DEPTH)
        ) result_fifo_i (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .in_valid_i  (res_valid[i]),
            .in_data_i   (res_data[i]),
            .in_ready_o  (res_ready[i]),
            .out_valid_o (fifo_valid[i]),
            .out_data_o  (fifo_data[i]),
            .out_ready_i (fifo_ready[i])   // grant from the arbiter
        );
    end

    cdb_arbiter cdb_arb_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .fifo_valid_i (fifo_valid),
        .fifo_data_i  (fifo_data),
        .fifo_ready_o (fifo_ready),
        .cdb_o        (cdb_o)
    );

endmodule

// ==== cdb_writeback.f ====
common/cdb_pkg.sv
hdl/handshake_fifo.sv
hdl/alu_lane.sv
cdb/cdb_arbiter.sv
cdb/cdb_writeback_top.sv
sim/clk_gen.sv
sim/cdb_chk.sv
sim/cdb_tb.sv

// ==== common/cdb_pkg.sv ====
package cdb_pkg;

    // datapath and tag widths
    localparam int XLEN     = 32;
    localparam int ROB_ID_W = 6;

    // writeback slice sizing
    localparam int FU_COUNT     = 4;
    localparam int CDB_COUNT    = 2;
    localparam int ISSUE_DEPTH  = 2;
    localparam int RESULT_DEPTH = 2;

    // index into the functional-unit lanes
    localparam int FU_IDX_W = $clog2(FU_COUNT);

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,   // signed compare
        OP_SLL = 3'd6,
        OP_SRL = 3'd7
    } alu_op_e;

    // issued micro-op, 73 bits
    typedef struct packed {
        alu_op_e op;
        word_t   src0;
        word_t   src1;
        rob_id_t rob_id;
    } fu_req_t;

    // one broadcast item on the cdb, 39 bits
    typedef struct packed {
        logic    w_valid;
        rob_id_t rob_id;
        word_t   w_data;
    } cdb_info_t;

endpackage

// ==== hdl/alu_lane.sv ====
`timescale 1ns/1ps

module alu_lane import cdb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,

    input  logic      req_valid_i,
    input  fu_req_t   req_i,
    output logic      req_ready_o,

    output logic      res_valid_o,
    output cdb_info_t res_o,
    input  logic      res_ready_i
);

    logic      valid_q;
    cdb_info_t res_q;
    word_t     alu_out;
    logic      accept;

    // take a new op when the output slot is empty or leaving this cycle
    assign req_ready_o = !valid_q || res_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        case (req_i.op)
            OP_ADD:  alu_out = req_i.src0 + req_i.src1;
            OP_SUB:  alu_out = req_i.src0 - req_i.src1;
            OP_AND:  alu_out = req_i.src0 & req_i.src1;
            OP_OR:   alu_out = req_i.src0 | req_i.src1;
            OP_XOR:  alu_out = req_i.src0 ^ req_i.src1;
            OP_SLT:  alu_out = ($signed(req_i.src0) < $signed(req_i.src1)) ? 32'd1 : 32'd0;
            OP_SLL:  alu_out = req_i.src0 << req_i.src1[4:0];
            OP_SRL:  alu_out = req_i.src0 >> req_i.src1[4:0]; // logical shift
            default: alu_out = '0;
        endcase
    end

    // result payload, only meaningful while valid_q is set
    always_ff @(posedge clk) begin
        if (accept) begin
            res_q.w_valid <= 1'b1;
            res_q.rob_id  <= req_i.rob_id;
            res_q.w_data  <= alu_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;     // drop anything in flight
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (res_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    assign res_valid_o = valid_q;
    assign res_o       = res_q;

endmodule

// ==== hdl/handshake_fifo.sv ====
`timescale 1ns/1ps

module handshake_fifo import cdb_pkg::*; #(
    parameter type T     = word_t,
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,

    input  logic in_valid_i,
    input  T     in_data_i,
    output logic in_ready_o,

    output logic out_valid_o,
    output T     out_data_o,
    input  logic out_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wrap works for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready_o  = (count != CNT_W'(DEPTH)); // low when full
    assign out_valid_o = (count != '0);
    assign out_data_o  = mem[rd_ptr];              // no bypass path

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            if (push && !pop)      count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cdb writeback testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cdb_tb \
    -f cdb_writeback.f -o cdb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/cdb_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

// ==== sim/cdb_chk.sv ====
`timescale 1ns/1ps

module cdb_chk import cdb_pkg::*; (
    input logic                       clk_i,
    input logic                       rst_n_i,
    input logic      [FU_COUNT-1:0]   valid_i,
    input logic      [FU_COUNT-1:0]   ready_i,
    input cdb_info_t [CDB_COUNT-1:0]  cdb_i
);

    int fail_cnt = 0;   // read by the testbench at the end

    two_lanes_distinct: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cdb_i[0].w_valid && cdb_i[1].w_valid) |-> (cdb_i[0].rob_id != cdb_i[1].rob_id))
        else begin
            $error("both cdb lanes carry the same rob_id");
            fail_cnt++;
        end

    // lane 1 is only used as the second grant
    lane1_needs_lane0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cdb_i[1].w_valid |-> cdb_i[0].w_valid)
        else begin
            $error("cdb lane 1 valid while lane 0 is idle");
            fail_cnt++;
        end

    idle_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> (!cdb_i[0].w_valid && !cdb_i[1].w_valid))
        else begin
            $error("cdb valid bit set during reset");
            fail_cnt++;
        end

    grant_only_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ready_i & ~valid_i) == '0)
        else begin
            $error("arbiter grants an empty result fifo");
            fail_cnt++;
        end

endmodule

bind cdb_arbiter cdb_chk chk_i (
    .clk_i   (clk),
    .rst_n_i (rst_n_i),
    .valid_i (fifo_valid_i),
    .ready_i (fifo_ready_o),
    .cdb_i   (cdb_o)
);

// ==== sim/cdb_tb.sv ====
`timescale 1ns/1ps

module cdb_tb import cdb_pkg::*; ();

    logic                      clk;
    logic                      rst_n;
    logic                      flush;
    logic      [FU_COUNT-1:0]  issue_valid;
    fu_req_t   [FU_COUNT-1:0]  issue_req;
    logic      [FU_COUNT-1:0]  issue_ready;
    cdb_info_t [CDB_COUNT-1:0] cdb;

    cdb_info_t           model_q [FU_COUNT][$];   // expected results, issue order
    int                  lane_of [64];            // rob_id to issuing lane
    int                  stall_cnt [FU_COUNT];
    logic [FU_COUNT-1:0] popped;
    logic [FU_COUNT-1:0] pend;                    // mirror of issue_valid
    rob_id_t             next_rob;
    string               cur_test;
    int                  seed = 47806;
    int                  budget = 0;
    int                  err_cnt = 0;             // monitor errors
    int                  drv_err = 0;             // sequence errors
    int                  full_seen = 0;
    int                  test_base = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;

    clk_gen clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

    cdb_writeback_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .flush_i       (flush),
        .issue_valid_i (issue_valid),
        .issue_req_i   (issue_req),
        .issue_ready_o (issue_ready),
        .cdb_o         (cdb)
    );

    function automatic int total_errors();
        return err_cnt + drv_err + dut_i.cdb_arb_i.chk_i.fail_cnt;
    endfunction

    function automatic cdb_info_t expected_result(input fu_req_t r);
        cdb_info_t e;
        logic      lt;
        // signs differ: the negative one is smaller
        lt = (r.src0[31] != r.src1[31]) ? r.src0[31] : (r.src0 < r.src1);
        e.w_valid = 1'b1;
        e.rob_id  = r.rob_id;
        case (r.op)
            OP_ADD:  e.w_data = r.src0 + r.src1;
            OP_SUB:  e.w_data = r.src0 + ~r.src1 + 32'd1;
            OP_AND:  e.w_data = r.src0 & r.src1;
            OP_OR:   e.w_data = r.src0 | r.src1;
            OP_XOR:  e.w_data = r.src0 ^ r.src1;
            OP_SLT:  e.w_data = {31'd0, lt};
            OP_SLL:  e.w_data = r.src0 << r.src1[4:0];
            default: e.w_data = r.src0 >> r.src1[4:0];
        endcase
        return e;
    endfunction

    function automatic fu_req_t make_req(input int lane);
        fu_req_t r;
        word_t   pick;
        pick     = $random(seed);
        r.op     = alu_op_e'(pick[2:0]);
        r.src0   = $random(seed);
        r.src1   = (pick[5:3] == 3'd0) ? r.src0 : word_t'($random(seed)); // equal now and then
        r.rob_id = next_rob;
        lane_of[next_rob] = lane;
        next_rob = next_rob + 1'b1;   // wraps modulo 64
        return r;
    endfunction

    task automatic compare_info(input cdb_info_t exp, input cdb_info_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", cur_test, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_rob(input rob_id_t exp, input rob_id_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected rob_id %0d, actual rob_id %0d", cur_test, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_broadcast(input cdb_info_t act);
        int        ln;
        cdb_info_t head;
        ln = lane_of[act.rob_id];
        if (model_q[ln].size() == 0) begin
            $display("ERROR %s: rob_id %0d was broadcast but lane %0d has nothing pending",
                     cur_test, act.rob_id, ln);
            err_cnt++;
        end else begin
            head = model_q[ln].pop_front();
            compare_rob(head.rob_id, act.rob_id);
            compare_info(head, act);
            popped[ln] = 1'b1;
        end
    endtask

    // monitor, sees values registered at the previous edge
    always @(posedge clk) begin
        popped = '0;
        if (rst_n) begin
            for (int c = 0; c < CDB_COUNT; c++) begin
                if (cdb[c].w_valid) check_broadcast(cdb[c]);
            end
            if (cdb[1].w_valid && !cdb[0].w_valid) begin
                $display("ERROR %s: single broadcast went out on lane 1", cur_test);
                err_cnt++;
            end
            for (int i = 0; i < FU_COUNT; i++) begin
                if (issue_valid[i] && issue_ready[i] && !flush) begin
                    model_q[i].push_back(expected_result(issue_req[i]));
                end
                if (issue_valid[i] && !issue_ready[i]) full_seen++;
                stall_cnt[i] = (model_q[i].size() != 0 && !popped[i]) ? stall_cnt[i] + 1 : 0;
                if (stall_cnt[i] == 200) begin
                    $display("ERROR %s: lane %0d made no progress for 200 cycles", cur_test, i);
                    err_cnt++;
                end
                if (flush) model_q[i].delete();   // flushed items must never appear
            end
        end
    end

    task automatic drive_cycle(input int density);
        @(posedge clk);
        for (int i = 0; i < FU_COUNT; i++) begin
            if (!pend[i] || issue_ready[i]) begin
                if (budget > 0 && ({$random(seed)} % 100) < density) begin
                    issue_req[i]   <= make_req(i);
                    issue_valid[i] <= 1'b1;
                    pend[i] = 1'b1;
                    budget--;
                end else begin
                    issue_valid[i] <= 1'b0;
                    pend[i] = 1'b0;
                end
            end
        end
    endtask

    task automatic run_burst(input int total, input int density, input int max_cycles);
        int cyc;
        budget = total;
        cyc    = 0;
        while ((budget > 0 || pend != '0) && cyc < max_cycles) begin
            drive_cycle(density);
            cyc++;
        end
        if (budget > 0 || pend != '0) begin
            $display("ERROR %s: issue side stuck after %0d cycles", cur_test, max_cycles);
            drv_err++;
            issue_valid <= '0;
            pend   = '0;
            budget = 0;
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int left;
        left = 0;
        for (int cyc = 0; cyc < max_cycles; cyc++) begin
            @(negedge clk);
            left = 0;
            for (int i = 0; i < FU_COUNT; i++) left += model_q[i].size();
            if (left == 0) break;
        end
        if (left != 0) begin
            $display("ERROR %s: %0d results missing after %0d cycles", cur_test, left, max_cycles);
            drv_err++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_base = total_errors();
    endtask

    task automatic end_test();
        int n;
        n = total_errors() - test_base;
        tests_run++;
        if (n == 0) begin
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, n);
        end
    endtask

    initial begin
        int base;
        issue_valid = '0;
        issue_req   = '0;
        flush       = 1'b0;
        pend        = '0;
        next_rob    = '0;

        begin_test("reset_state");
        for (int cyc = 0; cyc < 50 && !rst_n; cyc++) @(negedge clk);
        if (!rst_n) begin
            $display("ERROR reset_state: reset was never released");
            drv_err++;
        end
        repeat (5) begin
            @(negedge clk);
            if (cdb[0].w_valid || cdb[1].w_valid) begin
                $display("ERROR reset_state: cdb broadcast with nothing issued");
                drv_err++;
            end
            if (issue_ready != '1) begin
                $display("ERROR reset_state: issue_ready low before any issue");
                drv_err++;
            end
        end
        end_test();

        begin_test("random_ops");
        run_burst(300, 60, 3000);
        wait_drain(200);
        end_test();

        begin_test("contention");
        base = full_seen;
        run_burst(160, 100, 2000);   // all lanes back to back
        wait_drain(200);
        if (full_seen == base) begin
            $display("ERROR contention: issue_ready never dropped");
            drv_err++;
        end
        end_test();

        begin_test("flush");
        budget = 16;
        repeat (6) drive_cycle(100);
        @(posedge clk);
        issue_valid <= '0;
        pend   = '0;
        budget = 0;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (20) @(posedge clk);  // any broadcast now is a flushed item
        run_burst(40, 70, 1000);
        wait_drain(200);
        end_test();

        repeat (5) @(posedge clk);
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // 10 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule
